/* verification/fetchPatterns.txt */
// op target data insn ip test, all fields hex
// op 1 write, 2 jump, 3 fetch; insn is checked on fetches only, ip after every op
1 000000 3A 00 000000 01
1 000001 5C 00 000000 02
1 000002 71 00 000000 03
1 000003 E4 00 000000 04
2 000000 00 00 000000 05
3 000000 00 3A 000001 06
3 000000 00 5C 000002 07
3 000000 00 71 000003 08
3 000000 00 E4 000004 09
// Decimal carry
1 000099 96 00 000004 0A
2 000099 00 00 000099 0B
3 000000 00 96 000100 0C
1 000999 2D 00 000100 0D
2 000999 00 00 000999 0E
3 000000 00 2D 001000 0F
// Bootloader region
2 999900 00 00 999900 10
3 000000 00 10 999901 11
3 000000 00 21 999902 12
3 000000 00 32 999903 13
// Dropped write into ROM
1 999905 5F 00 999903 14
2 999905 00 00 999905 15
3 000000 00 A5 999906 16
// Wrap to zero
2 999999 00 00 999999 17
3 000000 00 00 000000 18
3 000000 00 3A 000001 19

/* compile.f */
hw/DekatronPkg.sv
hw/Bootloader.sv
hw/IpMemory.sv
hw/IpCounter.sv
hw/FetchControl.sv
hw/InsnFetchTop.sv
verification/InsnFetchTb.sv

/* Bender.yml */
package:
  name: insn_fetch

sources:
  - files:
      - hw/DekatronPkg.sv
      - hw/Bootloader.sv
      - hw/IpMemory.sv
      - hw/IpCounter.sv
      - hw/FetchControl.sv
      - hw/InsnFetchTop.sv
  - target: test
    files:
      - verification/InsnFetchTb.sv

/* verification/InsnFetchTb.sv */
`timescale 1ns/1ps

module InsnFetchTb;

    import DekatronPkg::*;

    localparam int NUM_RECORDS = 25;
    localparam int FIELDS      = 6;    // Words per pattern record
    localparam int TIMEOUT     = 50;

    typedef enum logic [3:0] {
        OpWrite = 4'h1,
        OpJump  = 4'h2,
        OpFetch = 4'h3
    } tbOp_t;

    logic                  Clk;
    logic                  Rst_n;
    logic                  Fetch;
    logic                  Write;
    logic                  Jump;
    logic [IP_WIDTH-1:0]   Target;
    logic [INSN_WIDTH-1:0] WriteData;
    logic [IP_WIDTH-1:0]   Ip;
    logic [INSN_WIDTH-1:0] Insn;
    logic                  InsnValid;
    logic                  WriteDone;
    logic                  Busy;

    logic [23:0] patterns [NUM_RECORDS*FIELDS];

    int passCount;
    int failCount;
    int testErrors;

    InsnFetchTop i_dut (
        .Clk       (Clk),
        .Rst_n     (Rst_n),
        .Fetch     (Fetch),
        .Write     (Write),
        .Jump      (Jump),
        .Target    (Target),
        .WriteData (WriteData),
        .Ip        (Ip),
        .Insn      (Insn),
        .InsnValid (InsnValid),
        .WriteDone (WriteDone),
        .Busy      (Busy)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // ********************
    // Helpers
    // ********************

    function automatic string opName(input tbOp_t op);
        case (op)
            OpWrite: return "write";
            OpJump:  return "jump";
            OpFetch: return "fetch";
            default: return "unknown";
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            testErrors++;
        end
    endtask

    // Polls at falling edges until the done pulse shows up
    task automatic waitForDone(input bit isWrite, input int testNum);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge Clk);
            seen = isWrite ? WriteDone : InsnValid;
            cycles++;
        end
        if (!seen) begin
            $display("Test %0d timed out: the %s pulse never came within %0d cycles",
                     testNum, isWrite ? "WriteDone" : "InsnValid", TIMEOUT);
            $display("sim failed");
            $finish;
        end
    endtask

    // All drive tasks start and end right after a falling edge
    task automatic writeWord(input logic [IP_WIDTH-1:0] addr,
                             input logic [INSN_WIDTH-1:0] data, input int testNum);
        Target    = addr;
        WriteData = data;
        Write     = 1'b1;
        @(negedge Clk);
        Write = 1'b0;
        checkValue($sformatf("test %0d write Busy", testNum), 32'h1, Busy);
        waitForDone(1'b1, testNum);
        @(negedge Clk);   // Back in Idle
    endtask

    task automatic jumpTo(input logic [IP_WIDTH-1:0] addr);
        Target = addr;
        Jump   = 1'b1;
        @(negedge Clk);
        Jump = 1'b0;
    endtask

    task automatic fetchWord(input int testNum, output logic [INSN_WIDTH-1:0] word);
        Fetch = 1'b1;
        @(negedge Clk);
        Fetch = 1'b0;
        checkValue($sformatf("test %0d fetch Busy", testNum), 32'h1, Busy);
        waitForDone(1'b0, testNum);
        word = Insn;
        @(negedge Clk);   // Ip has stepped by now
    endtask

    task automatic reportTest(input int testNum, input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d %s: ok", testNum, name);
        end else begin
            failCount++;
            $display("test %0d %s: %0d mismatch(es)", testNum, name, testErrors);
        end
    endtask

    // ********************
    // Main sequence
    // ********************

    initial begin
        tbOp_t                 op;
        logic [IP_WIDTH-1:0]   addr;
        logic [INSN_WIDTH-1:0] data;
        logic [INSN_WIDTH-1:0] expInsn;
        logic [IP_WIDTH-1:0]   expIp;
        logic [INSN_WIDTH-1:0] word;
        logic [IP_WIDTH-1:0]   aliasAddr;
        logic [INSN_WIDTH-1:0] aliasWord;
        bit                    romWrite;
        int                    testNum;
        string                 name;

        Rst_n     = 1'b0;
        Fetch     = 1'b0;
        Write     = 1'b0;
        Jump      = 1'b0;
        Target    = '0;
        WriteData = '0;
        passCount = 0;
        failCount = 0;
        $readmemh("verification/fetchPatterns.txt", patterns);

        repeat (16) @(negedge Clk);
        Rst_n = 1'b1;
        @(negedge Clk);

        testErrors = 0;
        checkValue("test 0 reset Ip", 32'h0, Ip);
        checkValue("test 0 reset Busy", 32'h0, Busy);
        checkValue("test 0 reset InsnValid", 32'h0, InsnValid);
        checkValue("test 0 reset WriteDone", 32'h0, WriteDone);
        checkValue("test 0 reset Insn", 32'h0, Insn);
        reportTest(0, "reset");

        for (int r = 0; r < NUM_RECORDS; r++) begin
            op         = tbOp_t'(patterns[r*FIELDS][3:0]);
            addr       = patterns[r*FIELDS+1];
            data       = patterns[r*FIELDS+2][INSN_WIDTH-1:0];
            expInsn    = patterns[r*FIELDS+3][INSN_WIDTH-1:0];
            expIp      = patterns[r*FIELDS+4];
            testNum    = patterns[r*FIELDS+5];
            name       = $sformatf("test %0d %s", testNum, opName(op));
            testErrors = 0;

            // Writes into 9999xx go nowhere, so the RAM row they alias keeps its word
            romWrite  = (op == OpWrite) &&
                        (addr[IP_WIDTH-1:ROM_DEKATRONS*DEKATRON_WIDTH] == BOOT_PREFIX);
            aliasAddr = addr & 24'h000FFF;
            aliasWord = ~data;
            if (romWrite)
                writeWord(aliasAddr, aliasWord, testNum);

            case (op)
                OpWrite: writeWord(addr, data, testNum);
                OpJump:  jumpTo(addr);
                OpFetch: begin
                    fetchWord(testNum, word);
                    checkValue({name, " Insn"}, expInsn, word);
                end
                default: begin
                    $display("Test %0d has an unknown operation code %0h", testNum, op);
                    testErrors++;
                end
            endcase
            checkValue({name, " Ip"}, expIp, Ip);
            checkValue({name, " Busy"}, 32'h0, Busy);

            if (romWrite) begin
                jumpTo(aliasAddr);
                fetchWord(testNum, word);
                checkValue({name, " RAM alias"}, aliasWord, word);
                jumpTo(expIp);   // Pointer back where the patterns expect it
            end
            reportTest(testNum, opName(op));
        end

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* hw/InsnFetchTop.sv */
`timescale 1ns/1ps

module InsnFetchTop (
    input  logic                                Clk,
    input  logic                                Rst_n,
    input  logic                                Fetch,
    input  logic                                Write,
    input  logic                                Jump,
    input  logic [DekatronPkg::IP_WIDTH-1:0]    Target,
    input  logic [DekatronPkg::INSN_WIDTH-1:0]  WriteData,
    output logic [DekatronPkg::IP_WIDTH-1:0]    Ip,
    output logic [DekatronPkg::INSN_WIDTH-1:0]  Insn,
    output logic                                InsnValid,
    output logic                                WriteDone,
    output logic                                Busy
);

    import DekatronPkg::*;

    logic                  request;
    logic                  we;
    logic                  ready;
    logic                  inc;
    logic                  load;
    logic [IP_WIDTH-1:0]   address;
    logic [INSN_WIDTH-1:0] insnIn;
    logic [INSN_WIDTH-1:0] insnOut;

    assign load = Jump & ~Busy;   // No jumps mid operation

    IpCounter i_ipCounter (
        .Clk       (Clk),
        .Rst_n     (Rst_n),
        .Inc       (inc),
        .Load      (load),
        .LoadValue (Target),
        .Ip        (Ip)
    );

    FetchControl i_fetchControl (
        .Clk       (Clk),
        .Rst_n     (Rst_n),
        .Fetch     (Fetch),
        .Write     (Write),
        .Ip        (Ip),
        .Target    (Target),
        .WriteData (WriteData),
        .Ready     (ready),
        .InsnOut   (insnOut),
        .Request   (request),
        .WE        (we),
        .Address   (address),
        .InsnIn    (insnIn),
        .Inc       (inc),
        .Insn      (Insn),
        .InsnValid (InsnValid),
        .WriteDone (WriteDone),
        .Busy      (Busy)
    );

    IpMemory i_ipMemory (
        .Clk     (Clk),
        .Rst_n   (Rst_n),
        .Request (request),
        .WE      (we),
        .Address (address),
        .InsnIn  (insnIn),
        .Ready   (ready),
        .InsnOut (insnOut)
    );

endmodule

/* hw/FetchControl.sv */
`timescale 1ns/1ps

module FetchControl (
    input  logic                                Clk,
    input  logic                                Rst_n,
    input  logic                                Fetch,
    input  logic                                Write,
    input  logic [DekatronPkg::IP_WIDTH-1:0]    Ip,
    input  logic [DekatronPkg::IP_WIDTH-1:0]    Target,
    input  logic [DekatronPkg::INSN_WIDTH-1:0]  WriteData,
    input  logic                                Ready,
    input  logic [DekatronPkg::INSN_WIDTH-1:0]  InsnOut,
    output logic                                Request,
    output logic                                WE,
    output logic [DekatronPkg::IP_WIDTH-1:0]    Address,
    output logic [DekatronPkg::INSN_WIDTH-1:0]  InsnIn,
    output logic                                Inc,
    output logic [DekatronPkg::INSN_WIDTH-1:0]  Insn,
    output logic                                InsnValid,
    output logic                                WriteDone,
    output logic                                Busy
);

    import DekatronPkg::*;

    fetchState_t state;

    logic                  opWrite;   // Kind of operation in flight
    logic [IP_WIDTH-1:0]   addrReg;
    logic [INSN_WIDTH-1:0] dataReg;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state   <= FetchIdle;
            opWrite <= 1'b0;
            Insn    <= '0;
        end else begin
            case (state)
                FetchIdle: begin
                    if (Write || Fetch) begin
                        opWrite <= Write;   // Write wins a tie
                        state   <= FetchIssue;
                    end
                end
                FetchIssue: state <= FetchWait;
                FetchWait: begin
                    if (Ready) begin
                        if (!opWrite)
                            Insn <= InsnOut;
                        state <= FetchDone;
                    end
                end
                default: state <= FetchIdle;   // Done lasts one cycle
            endcase
        end
    end

    // Operation payload
    always_ff @(posedge Clk) begin
        if (state == FetchIdle) begin
            addrReg <= Write ? Target : Ip;
            dataReg <= WriteData;
        end
    end

    assign Request   = (state == FetchIssue);
    assign WE        = Request & opWrite;
    assign Address   = addrReg;
    assign InsnIn    = dataReg;
    assign InsnValid = (state == FetchDone) & ~opWrite;
    assign Inc       = InsnValid;   // Ip steps after each fetch only
    assign WriteDone = (state == FetchDone) & opWrite;
    assign Busy      = (state != FetchIdle);

endmodule

/* hw/IpCounter.sv */
`timescale 1ns/1ps

module IpCounter (
    input  logic                              Clk,
    input  logic                              Rst_n,
    input  logic                              Inc,
    input  logic                              Load,
    input  logic [DekatronPkg::IP_WIDTH-1:0]  LoadValue,
    output logic [DekatronPkg::IP_WIDTH-1:0]  Ip
);

    import DekatronPkg::*;

    logic [IP_DEKATRON_NUM-1:0] carry;   // Carry into each digit
    logic [IP_WIDTH-1:0]        ipInc;

    assign carry[0] = 1'b1;

    // ********************
    // Decimal increment
    // ********************

    for (genvar i = 0; i < IP_DEKATRON_NUM; i++) begin : gDigit
        logic [DEKATRON_WIDTH-1:0] digit;
        logic                      wrap;

        assign digit = Ip[i*DEKATRON_WIDTH +: DEKATRON_WIDTH];
        assign wrap  = (digit >= 4'd9);

        always_comb begin
            if (!carry[i])
                ipInc[i*DEKATRON_WIDTH +: DEKATRON_WIDTH] = digit;
            else if (wrap)
                ipInc[i*DEKATRON_WIDTH +: DEKATRON_WIDTH] = '0;
            else
                ipInc[i*DEKATRON_WIDTH +: DEKATRON_WIDTH] = digit + 4'd1;
        end

        // Top digit drops its carry, 999999 wraps
        if (i < IP_DEKATRON_NUM - 1) begin : gCarry
            assign carry[i+1] = carry[i] & wrap;
        end
    end

    // ********************
    // Pointer register
    // ********************

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            Ip <= '0;
        end else if (Load) begin
            Ip <= LoadValue;   // Jump wins over increment
        end else if (Inc) begin
            Ip <= ipInc;
        end
    end

endmodule

/* hw/IpMemory.sv */
`timescale 1ns/1ps

module IpMemory (
    input  logic                                Clk,
    input  logic                                Rst_n,
    input  logic                                Request,
    input  logic                                WE,
    input  logic [DekatronPkg::IP_WIDTH-1:0]    Address,
    input  logic [DekatronPkg::INSN_WIDTH-1:0]  InsnIn,
    output logic                                Ready,
    output logic [DekatronPkg::INSN_WIDTH-1:0]  InsnOut
);

    import DekatronPkg::*;

    localparam int RAM_ADDR_WIDTH = RAM_DEKATRONS * DEKATRON_WIDTH;
    localparam int ROM_ADDR_WIDTH = ROM_DEKATRONS * DEKATRON_WIDTH;
    localparam int RAM_ROWS       = 1 << RAM_ADDR_WIDTH;

    memState_t state;
    memState_t next;

    logic                      isBootloader;
    logic [INSN_WIDTH-1:0]     romOutWire;
    logic [INSN_WIDTH-1:0]     romOutReg;
    logic [INSN_WIDTH-1:0]     ramOutReg;
    logic [RAM_ADDR_WIDTH-1:0] ramIndex;

    logic [INSN_WIDTH-1:0] mem [RAM_ROWS];

    // ********************
    // Address decode
    // ********************

    assign isBootloader = (Address[IP_WIDTH-1:ROM_ADDR_WIDTH] == BOOT_PREFIX);
    assign ramIndex     = Address[RAM_ADDR_WIDTH-1:0];   // Raw bits, higher digits alias

    Bootloader i_bootloader (
        .Address (Address[ROM_ADDR_WIDTH-1:0]),
        .Data    (romOutWire)
    );

    // ********************
    // Controller
    // ********************

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= MemInit;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            MemInit: begin
                if (Request)
                    next = MemBusy;
            end
            MemReady: begin
                if (Request)
                    next = MemBusy;
            end
            MemBusy:  next = MemReady;   // Single-cycle access
            default:  next = MemInit;
        endcase
    end

    assign Ready = ~Request & (state == MemReady);

    // ********************
    // Storage
    // ********************

    always_ff @(posedge Clk) begin
        if (Request) begin
            if (WE) begin
                if (!isBootloader)
                    mem[ramIndex] <= InsnIn;   // ROM region is read only
            end else begin
                ramOutReg <= mem[ramIndex];
                romOutReg <= romOutWire;
            end
        end
    end

    assign InsnOut = isBootloader ? romOutReg : ramOutReg;

endmodule

/* hw/Bootloader.sv */
`timescale 1ns/1ps

module Bootloader (
    input  logic [DekatronPkg::ROM_DEKATRONS*DekatronPkg::DEKATRON_WIDTH-1:0] Address,
    output logic [DekatronPkg::INSN_WIDTH-1:0]                                 Data
);

    // Fixed loader program, indexed by two BCD digits
    always_comb begin
        case (Address)
            8'h00:   Data = 8'h10;
            8'h01:   Data = 8'h21;
            8'h02:   Data = 8'h32;
            8'h03:   Data = 8'h4C;
            8'h04:   Data = 8'h57;
            8'h05:   Data = 8'hA5;   // Checked against dropped write
            8'h06:   Data = 8'h63;
            8'h07:   Data = 8'h7E;
            8'h08:   Data = 8'h81;
            8'h09:   Data = 8'h9B;
            8'h10:   Data = 8'hC4;
            8'h11:   Data = 8'hD2;
            8'h12:   Data = 8'hE8;
            8'h13:   Data = 8'h3F;
            8'h14:   Data = 8'h5A;
            8'h15:   Data = 8'h66;
            8'h16:   Data = 8'h29;
            8'h17:   Data = 8'hB7;
            8'h18:   Data = 8'hF0;   // Loop back to start
            8'h19:   Data = 8'h0F;
            default: Data = 8'h00;
        endcase
    end

endmodule

/* hw/DekatronPkg.sv */
package DekatronPkg;

    // ********************
    // Digit and word sizes
    // ********************

    localparam int DEKATRON_WIDTH  = 4;   // One BCD digit per dekatron
    localparam int IP_DEKATRON_NUM = 6;
    localparam int IP_WIDTH        = IP_DEKATRON_NUM * DEKATRON_WIDTH;
    localparam int INSN_WIDTH      = 8;

    // ********************
    // Memory map
    // ********************

    // Low digits indexing each store
    localparam int ROM_DEKATRONS = 2;
    localparam int RAM_DEKATRONS = 3;

    // Top four digits of the bootloader region
    localparam logic [(IP_DEKATRON_NUM-ROM_DEKATRONS)*DEKATRON_WIDTH-1:0] BOOT_PREFIX =
        16'h9999;

    // ********************
    // Controller states
    // ********************

    typedef enum logic [1:0] {
        MemInit  = 2'd0,
        MemReady = 2'd1,
        MemBusy  = 2'd2
    } memState_t;

    typedef enum logic [1:0] {
        FetchIdle  = 2'd0,
        FetchIssue = 2'd1,   // Request pulse
        FetchWait  = 2'd2,   // Hold until memory Ready
        FetchDone  = 2'd3
    } fetchState_t;

endpackage
